// File: compile.f
hdl/mixPkg.sv
hdl/mixIndex.sv
hdl/mixField.sv
hdl/mixAddSub.sv
hdl/mixCompare.sv
hdl/mixStore.sv
hdl/mixCore.sv
tests/clockGen.sv
tests/mixChecker.sv
tests/mixTb.sv

// File: run.sh
#!/bin/sh
# builds the MIX core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module mixTb -f compile.f -o mixSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/mixSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

// File: tests/mixTb.sv
/*
 MIX core testbench. Each table row loads a short program and two data
 words through the load port, pulses go and lets the checker compare
 the registers once the core halts. Registers carry over between rows.
*/
`timescale 1ns/100ps
`default_nettype none

module mixTb;
	import mixPkg::*;

	localparam int rowCount = 20;
	// four program words, the HLT and two data words
	localparam int loadWrites = 7;
	localparam int timeoutCycles = rowCount * (loadWrites + 40);

	logic clk;
	logic reset;
	logic go;
	logic loadEnable;
	mixAddr loadAddress;
	mixWord loadWord;
	logic halted;
	mixWord regA;
	mixWord regX;
	mixAddr regJ;
	logic overflowFlag;
	logic [1:0] compareCode;

	logic armed;
	logic done;
	int errorCount;
	logic [8*16-1:0] testName;
	mixWord expA;
	mixWord expX;
	mixAddr expJ;
	logic expOverflow;
	logic [1:0] expCompare;

	logic [8*16-1:0] names [rowCount];
	mixWord progWords [rowCount][4];
	mixWord dataWords [rowCount][2];
	mixWord tableA [rowCount];
	mixWord tableX [rowCount];
	mixAddr tableJ [rowCount];
	logic tableOv [rowCount];
	logic [1:0] tableCmp [rowCount];
	int rowFill = 0;
	int cycleCount = 0;

	clockGen clocks (.clk(clk), .reset(reset));

	mixCore #(.memWords(4096)) UUT (
		.clk(clk),
		.reset(reset),
		.go(go),
		.loadEnable(loadEnable),
		.loadAddress(loadAddress),
		.loadWord(loadWord),
		.halted(halted),
		.regA(regA),
		.regX(regX),
		.regJ(regJ),
		.overflowFlag(overflowFlag),
		.compareCode(compareCode)
	);

	mixChecker resultCheck (
		.clk(clk), .reset(reset), .halted(halted),
		.regA(regA), .regX(regX), .regJ(regJ),
		.overflowFlag(overflowFlag), .compareCode(compareCode),
		.armed(armed), .testName(testName),
		.expA(expA), .expX(expX), .expJ(expJ),
		.expOverflow(expOverflow), .expCompare(expCompare),
		.done(done), .errorCount(errorCount)
	);

	// +AA I F C with a non-negative address
	function automatic mixWord encode(input int addr, input int idx, input int field,
		input int op);
		return {1'b0, 12'(addr), 6'(idx), 6'(field), 6'(op)};
	endfunction

	function automatic mixWord packBytes(input logic sign, input logic [5:0] b1,
		input logic [5:0] b2, input logic [5:0] b3, input logic [5:0] b4,
		input logic [5:0] b5);
		return {sign, b1, b2, b3, b4, b5};
	endfunction

	function automatic mixWord signMag(input logic sign, input logic [29:0] mag);
		return {sign, mag};
	endfunction

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// sign-magnitude add, returns overflow above the 31-bit word
	function automatic logic [31:0] addRule(input mixWord a, input mixWord b,
		input logic subtract);
		longint valA;
		longint valB;
		longint total;
		longint mag;
		logic signR;
		logic carry;
		valA = a[30] ? -longint'(a[29:0]) : longint'(a[29:0]);
		valB = b[30] ? -longint'(b[29:0]) : longint'(b[29:0]);
		total = subtract ? valA - valB : valA + valB;
		mag = (total < 0) ? -total : total;
		// a zero sum takes the sign of the first operand
		signR = (total == 0) ? a[30] : (total < 0);
		carry = mag >= (longint'(1) << 30);
		return {carry, signR, mag[29:0]};
	endfunction

	task automatic addRow(input logic [8*16-1:0] name, input mixWord w0, input mixWord w1,
		input mixWord w2, input mixWord w3, input mixWord d0, input mixWord d1,
		input mixWord a, input mixWord x, input mixAddr j, input logic ov,
		input logic [1:0] cmp);
		names[rowFill] = name;
		progWords[rowFill][0] = w0;
		progWords[rowFill][1] = w1;
		progWords[rowFill][2] = w2;
		progWords[rowFill][3] = w3;
		dataWords[rowFill][0] = d0;
		dataWords[rowFill][1] = d1;
		tableA[rowFill] = a;
		tableX[rowFill] = x;
		tableJ[rowFill] = j;
		tableOv[rowFill] = ov;
		tableCmp[rowFill] = cmp;
		rowFill = rowFill + 1;
	endtask

	task automatic buildTable();
		logic [31:0] seed;
		logic [31:0] result;
		mixWord opA;
		mixWord opB;
		mixWord xNow;
		mixWord nop;
		mixAddr jNow;
		nop = '0;
		xNow = packBytes(1, 0, 0, 0, 7, 9);
		addRow("ldPartial", encode(100, 0, 11, 8), encode(100, 0, 2, 15), nop, nop,
			packBytes(1, 1, 2, 3, 4, 5), nop,
			packBytes(0, 0, 0, 1, 2, 3), packBytes(1, 0, 0, 0, 1, 2), 12'd0, 1'b0, cmpEqual);
		addRow("ldNegative", encode(100, 0, 5, 16), encode(101, 0, 37, 23), nop, nop,
			packBytes(0, 10, 20, 30, 40, 50), packBytes(0, 0, 0, 0, 7, 9),
			packBytes(1, 10, 20, 30, 40, 50), xNow, 12'd0, 1'b0, cmpEqual);
		addRow("addMixedSigns", encode(100, 0, 5, 8), encode(101, 0, 5, 1), nop, nop,
			signMag(0, 1000), signMag(1, 300), signMag(0, 700), xNow, 12'd0, 1'b0, cmpEqual);
		addRow("subZeroSign", encode(100, 0, 5, 8), encode(101, 0, 5, 2), nop, nop,
			signMag(1, 500), signMag(1, 500), signMag(1, 0), xNow, 12'd0, 1'b0, cmpEqual);
		addRow("addCarryOverflow", encode(100, 0, 5, 8), encode(101, 0, 5, 1), nop, nop,
			signMag(0, 30'h3fffffff), signMag(0, 2), signMag(0, 1), xNow, 12'd0, 1'b1, cmpEqual);
		// JOV skips the ENTA and clears the toggle
		addRow("jovTaken", encode(2, 0, 2, 39), encode(7, 0, 2, 48), nop, nop,
			nop, nop, signMag(0, 1), xNow, 12'd1, 1'b0, cmpEqual);
		// random operands, a JOV at 2 leaves J at 3 only on overflow
		seed = 32'hbd7a;
		jNow = 12'd1;
		for (int n = 0; n < 4; n++) begin
			seed = lcgStep(seed);
			opA = {seed[31], seed[30:1]};
			seed = lcgStep(seed);
			opB = {seed[31], seed[30:1]};
			result = addRule(opA, opB, n[0]);
			if (result[31]) begin
				jNow = 12'd3;
			end
			addRow({"lcgRow", 8'(8'h30 + n)}, encode(100, 0, 5, 8),
				encode(101, 0, 5, n[0] ? 2 : 1), encode(3, 0, 2, 39), nop,
				opA, opB, result[30:0], xNow, jNow, 1'b0, cmpEqual);
		end
		addRow("staField", encode(100, 0, 5, 8), encode(101, 0, 19, 24), encode(101, 0, 5, 8),
			nop, packBytes(1, 0, 0, 0, 33, 44), packBytes(0, 1, 2, 3, 4, 5),
			packBytes(0, 1, 33, 44, 4, 5), xNow, jNow, 1'b0, cmpEqual);
		addRow("stzField", encode(101, 0, 36, 33), encode(101, 0, 5, 8), nop, nop,
			nop, packBytes(1, 7, 8, 9, 10, 11),
			packBytes(1, 7, 8, 9, 0, 11), xNow, jNow, 1'b0, cmpEqual);
		addRow("stjReload", nop, encode(2, 0, 0, 39), encode(101, 0, 19, 32),
			encode(101, 0, 5, 8), nop, packBytes(1, 63, 63, 63, 63, 63),
			packBytes(1, 63, 0, 2, 63, 63), xNow, 12'd2, 1'b0, cmpEqual);
		addRow("cmpLessSkip", encode(100, 0, 5, 8), encode(101, 0, 5, 56), encode(4, 0, 4, 39),
			encode(7, 0, 2, 48), signMag(0, 5), signMag(0, 9),
			signMag(0, 5), xNow, 12'd3, 1'b0, cmpLess);
		addRow("cmpEqualFall", encode(100, 0, 5, 8), encode(101, 0, 5, 56), encode(4, 0, 6, 39),
			encode(7, 0, 2, 48), signMag(1, 0), signMag(0, 0),
			signMag(0, 7), xNow, 12'd3, 1'b0, cmpEqual);
		addRow("cmpGreaterJump", encode(100, 0, 5, 8), encode(101, 0, 5, 56), encode(4, 0, 6, 39),
			encode(7, 0, 2, 48), signMag(1, 3), signMag(1, 10),
			signMag(1, 3), xNow, 12'd3, 1'b0, cmpGreater);
		addRow("cmpGreaterFall", encode(100, 0, 5, 8), encode(101, 0, 5, 56), encode(4, 0, 5, 39),
			encode(7, 0, 2, 48), packBytes(0, 1, 2, 3, 4, 5), packBytes(0, 1, 2, 3, 4, 4),
			signMag(0, 7), xNow, 12'd3, 1'b0, cmpGreater);
		addRow("indexLoad", encode(5, 0, 2, 49), encode(95, 1, 5, 8), nop, nop,
			packBytes(0, 9, 8, 7, 6, 5), nop,
			packBytes(0, 9, 8, 7, 6, 5), xNow, 12'd3, 1'b0, cmpGreater);
		addRow("incaOverflow", encode(100, 0, 5, 8), encode(4095, 0, 0, 48), nop, nop,
			signMag(0, 30'h3fffff9c), nop, signMag(0, 3995), xNow, 12'd3, 1'b1, cmpGreater);
		addRow("decaJovClear", encode(1, 0, 3, 39), encode(100, 0, 5, 8), encode(4095, 0, 1, 48),
			encode(4, 0, 2, 39), signMag(1, 30'h3fffff9c), nop,
			signMag(1, 3995), xNow, 12'd4, 1'b0, cmpGreater);
	endtask

	task automatic runRow(input int row);
		for (int n = 0; n < 4; n++) begin
			@(posedge clk);
			loadEnable <= 1'b1;
			loadAddress <= 12'(n);
			loadWord <= progWords[row][n];
		end
		@(posedge clk);
		loadAddress <= 12'd4;
		loadWord <= encode(0, 0, 2, 5);
		@(posedge clk);
		loadAddress <= 12'd100;
		loadWord <= dataWords[row][0];
		@(posedge clk);
		loadAddress <= 12'd101;
		loadWord <= dataWords[row][1];
		@(posedge clk);
		loadEnable <= 1'b0;
		go <= 1'b1;
		armed <= 1'b1;
		testName <= names[row];
		expA <= tableA[row];
		expX <= tableX[row];
		expJ <= tableJ[row];
		expOverflow <= tableOv[row];
		expCompare <= tableCmp[row];
		@(posedge clk);
		go <= 1'b0;
		do @(posedge clk); while (!done);
		armed <= 1'b0;
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout after %0d cycles, the core never halted", cycleCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		go = 1'b0;
		loadEnable = 1'b0;
		loadAddress = '0;
		loadWord = '0;
		armed = 1'b0;
		testName = '0;
		expA = '0;
		expX = '0;
		expJ = '0;
		expOverflow = 1'b0;
		expCompare = cmpEqual;
		buildTable();
		@(posedge clk);
		while (reset) @(posedge clk);
		for (int row = 0; row < rowCount; row++) begin
			runRow(row);
		end
		@(posedge clk);
		$display("ran %0d tests, %0d errors", rowCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/mixChecker.sv
/*
 Result checker for the MIX core testbench. When the core halts after a
 go it compares A, X, J, overflow and the compare code with the
 expected values of the current test, and flags a core that never halts.
*/
`timescale 1ns/100ps
`default_nettype none

module mixChecker (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 halted,
	input  wire mixPkg::mixWord regA,
	input  wire mixPkg::mixWord regX,
	input  wire mixPkg::mixAddr regJ,
	input  wire                 overflowFlag,
	input  wire [1:0]           compareCode,
	input  wire                 armed,
	input  wire [8*16-1:0]      testName,
	input  wire mixPkg::mixWord expA,
	input  wire mixPkg::mixWord expX,
	input  wire mixPkg::mixAddr expJ,
	input  wire                 expOverflow,
	input  wire [1:0]           expCompare,
	output logic                done,
	output int                  errorCount
);
	import mixPkg::*;

	// longest program is well under this
	localparam int haltLimit = 40;

	logic wasHalted;
	int waitCycles;

	task automatic compareValue(input string what, input logic [30:0] expected,
		input logic [30:0] actual);
		if (expected !== actual) begin
			$display("FAILED %0s: %0s expected %h actual %h", testName, what, expected, actual);
			errorCount = errorCount + 1;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			errorCount = 0;
			done <= 1'b0;
			wasHalted <= 1'b1;
			waitCycles <= 0;
		end else begin
			wasHalted <= halted;
			done <= 1'b0;
			if (!armed) begin
				waitCycles <= 0;
			end else if (!done) begin
				// rising halted marks the end of the program
				if (halted && !wasHalted) begin
					compareValue("A", expA, regA);
					compareValue("X", expX, regX);
					compareValue("J", 31'(expJ), 31'(regJ));
					compareValue("overflow", 31'(expOverflow), 31'(overflowFlag));
					compareValue("compare code", 31'(expCompare), 31'(compareCode));
					done <= 1'b1;
				end else if (waitCycles >= haltLimit) begin
					$display("core never halted in test %0s", testName);
					errorCount = errorCount + 1;
					done <= 1'b1;
				end else begin
					waitCycles <= waitCycles + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/clockGen.sv
/*
 Testbench clock and reset: 100 ns period, reset held for 3 cycles.
*/
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: hdl/mixCore.sv
/*
 MIX core: fetch/decode/operate sequencer, program counter, registers
 A, X, J and I1-I6, overflow and comparison flags, the word memory and
 a load port that writes memory while the core is halted.
*/
`timescale 1ns/100ps
`default_nettype none

module mixCore #(
	parameter int memWords = 4096
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 go,
	input  wire                 loadEnable,
	input  wire mixPkg::mixAddr loadAddress,
	input  wire mixPkg::mixWord loadWord,
	output logic                halted,
	output mixPkg::mixWord      regA,
	output mixPkg::mixWord      regX,
	output mixPkg::mixAddr      regJ,
	output logic                overflowFlag,
	output logic [1:0]          compareCode
);
	import mixPkg::*;

	typedef enum logic [1:0] {stIdle, stFetch, stDecode, stOperate} coreState;

	coreState state;
	mixWord memory [0:memWords-1];
	mixWord readData;
	mixAddr readAddr;
	logic memWrite;
	mixAddr writeAddr;
	mixWord writeData;

	mixAddr pc;
	mixWord ir;
	mixWord instr;
	mixIndexReg effAddress;
	mixIndexReg eaReg;
	mixWord eaWord;
	mixIndexReg idxReg [1:6];

	logic [5:0] op;
	logic [5:0] fieldSpec;
	logic [5:0] indexField;
	logic [2:0] indexSel;
	logic [2:0] regSel;
	logic isAdd;
	logic isSub;
	logic isHlt;
	logic isLoad;
	logic isLoadNeg;
	logic isStore;
	logic isJump;
	logic ideActive;
	logic isCmp;
	logic usesOperand;

	mixWord selWord;
	mixWord operandValue;
	mixWord registerValue;
	mixWord loadValue;
	mixWord ideValue;
	mixWord regValue;
	mixWord storeSource;
	mixWord storedWord;
	logic regWrite;

	logic addStart;
	logic addStop;
	logic addSubtract;
	logic addOverflow;
	mixWord addIn1;
	mixWord addIn2;
	mixWord addSum;
	logic cmpStart;
	logic cmpStop;
	logic [1:0] cmpResult;
	logic jumpCond;
	logic jumpTaken;

	assign halted = state == stIdle;

	// synchronous memory with one read and one write port
	always_ff @(posedge clk) begin
		if (memWrite) begin
			memory[writeAddr] <= writeData;
		end
		readData <= memory[readAddr];
	end

	assign readAddr = (state == stFetch) ? pc : effAddress[addrWidth-1:0];
	assign memWrite = (halted && loadEnable) || (state == stOperate && isStore);
	assign writeAddr = halted ? loadAddress : eaReg[addrWidth-1:0];
	assign writeData = halted ? loadWord : storedWord;

	// the fetched word is decoded straight off the memory output
	assign instr = (state == stDecode) ? readData : ir;
	assign op = instr[opFieldHi:opFieldLo];
	assign fieldSpec = instr[specFieldHi:specFieldLo];
	assign indexField = instr[indexFieldHi:indexFieldLo];
	assign regSel = op[2:0];

	assign isAdd = op == opAdd;
	assign isSub = op == opSub;
	assign isHlt = op == opSpecial && fieldSpec == fieldHlt;
	assign isLoad = op[5:3] == opLdBase[5:3];
	assign isLoadNeg = op[5:3] == opLdnBase[5:3];
	assign isStore = op[5:3] == opStBase[5:3] || op == opStj || op == opStz;
	assign isJump = op == opJmp;
	assign ideActive = op[5:3] == opIdeBase[5:3] && fieldSpec <= fieldEnn;
	assign isCmp = op[5:3] == opCmpBase[5:3];
	assign usesOperand = isAdd || isSub || isLoad || isLoadNeg || isStore || isCmp;

	assign indexSel = (indexField <= 6'd6) ? indexField[2:0] : 3'd0;

	mixIndex addrCalc (
		.addressIn(instr[addrFieldHi:addrFieldLo]),
		.indexSel(indexSel),
		.i1(idxReg[1]),
		.i2(idxReg[2]),
		.i3(idxReg[3]),
		.i4(idxReg[4]),
		.i5(idxReg[5]),
		.i6(idxReg[6]),
		.effAddress(effAddress)
	);

	assign eaWord = {effAddress[addrWidth], {(wordWidth-addrWidth-1){1'b0}},
		effAddress[addrWidth-1:0]};

	// register named by the low opcode bits, index registers widened
	always_comb begin
		case (regSel)
			3'd0: selWord = regA;
			3'd7: selWord = regX;
			default: selWord = {idxReg[regSel][addrWidth],
				{(wordWidth-addrWidth-1){1'b0}}, idxReg[regSel][addrWidth-1:0]};
		endcase
	end

	mixField operandField (
		.word(readData),
		.fieldSpec(fieldSpec),
		.value(operandValue)
	);

	mixField registerField (
		.word(selWord),
		.fieldSpec(fieldSpec),
		.value(registerValue)
	);

	// adder serves ADD/SUB in operate and INC/DEC in decode
	assign addStart = state == stDecode && (isAdd || isSub);
	assign addIn1 = (state == stOperate) ? regA : selWord;
	assign addIn2 = (state == stOperate) ? operandValue : eaWord;
	assign addSubtract = (state == stOperate) ? isSub : fieldSpec == fieldDec;

	mixAddSub adder (
		.clk(clk),
		.reset(reset),
		.start(addStart),
		.subtract(addSubtract),
		.in1(addIn1),
		.in2(addIn2),
		.stop(addStop),
		.sum(addSum),
		.overflow(addOverflow)
	);

	assign cmpStart = state == stDecode && isCmp;

	mixCompare comparator (
		.clk(clk),
		.reset(reset),
		.start(cmpStart),
		.in1(registerValue),
		.in2(operandValue),
		.stop(cmpStop),
		.code(cmpResult)
	);

	always_comb begin
		if (op == opStz) begin
			storeSource = '0;
		end else if (op == opStj) begin
			storeSource = {{(wordWidth-addrWidth){1'b0}}, regJ};
		end else begin
			storeSource = selWord;
		end
	end

	mixStore merger (
		.oldWord(readData),
		.source(storeSource),
		.fieldSpec(fieldSpec),
		.newWord(storedWord)
	);

	always_comb begin
		case (fieldSpec)
			jmpAlways, jmpSaveJ: jumpCond = 1'b1;
			jmpOverflow: jumpCond = overflowFlag;
			jmpNoOverflow: jumpCond = !overflowFlag;
			jmpLess: jumpCond = compareCode == cmpLess;
			jmpEqual: jumpCond = compareCode == cmpEqual;
			jmpGreater: jumpCond = compareCode == cmpGreater;
			jmpGreaterEqual: jumpCond = compareCode != cmpLess;
			jmpNotEqual: jumpCond = compareCode != cmpEqual;
			jmpLessEqual: jumpCond = compareCode != cmpGreater;
			default: jumpCond = 1'b0;
		endcase
	end

	assign jumpTaken = state == stDecode && isJump && jumpCond;

	always_comb begin
		case (fieldSpec)
			fieldInc, fieldDec: ideValue = addSum;
			fieldEnt: ideValue = eaWord;
			default: ideValue = {~eaWord[wordWidth-1], eaWord[wordWidth-2:0]};
		endcase
	end

	assign loadValue = {operandValue[wordWidth-1] ^ isLoadNeg, operandValue[wordWidth-2:0]};
	assign regWrite = (state == stDecode && ideActive) ||
		(state == stOperate && (isLoad || isLoadNeg));
	assign regValue = (state == stOperate) ? loadValue : ideValue;

	always_ff @(posedge clk) begin
		if (state == stDecode) begin
			ir <= readData;
			eaReg <= effAddress;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regA <= '0;
			regX <= '0;
			for (int n = 1; n <= 6; n++) begin
				idxReg[n] <= '0;
			end
		end else begin
			if (addStop) begin
				regA <= addSum;
			end else if (regWrite && regSel == 3'd0) begin
				regA <= regValue;
			end
			if (regWrite && regSel == 3'd7) begin
				regX <= regValue;
			end
			// index registers keep sign and low 12 bits
			for (int n = 1; n <= 6; n++) begin
				if (regWrite && regSel == 3'(n)) begin
					idxReg[n] <= {regValue[wordWidth-1], regValue[addrWidth-1:0]};
				end
			end
		end
	end

	// sequencer, program counter, J and the flags
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			pc <= '0;
			regJ <= '0;
			overflowFlag <= 1'b0;
			compareCode <= cmpEqual;
		end else begin
			case (state)
				stIdle: begin
					if (go) begin
						state <= stFetch;
						pc <= '0;
					end
				end
				stFetch: begin
					state <= stDecode;
				end
				stDecode: begin
					pc <= jumpTaken ? effAddress[addrWidth-1:0] : pc + 1'b1;
					if (isHlt) begin
						state <= stIdle;
					end else if (usesOperand) begin
						state <= stOperate;
					end else begin
						state <= stFetch;
					end
					if (jumpTaken && fieldSpec != jmpSaveJ) begin
						regJ <= pc + 1'b1;
					end
					// JOV and JNOV always turn the toggle off
					if (isJump && (fieldSpec == jmpOverflow || fieldSpec == jmpNoOverflow)) begin
						overflowFlag <= 1'b0;
					end else if (ideActive && fieldSpec <= fieldDec && addOverflow &&
						(regSel == 3'd0 || regSel == 3'd7)) begin
						overflowFlag <= 1'b1;
					end
				end
				default: begin
					state <= stFetch;
					// overflow is sticky until a JOV or JNOV
					if (addStop && addOverflow) begin
						overflowFlag <= 1'b1;
					end
					if (cmpStop) begin
						compareCode <= cmpResult;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/mixStore.sv
/*
 Store merge: puts the low bytes of the source into bytes L..R of the
 old memory word, and the source sign as well when L is zero.
*/
`timescale 1ns/100ps
`default_nettype none

module mixStore (
	input  wire mixPkg::mixWord oldWord,
	input  wire mixPkg::mixWord source,
	input  wire [5:0]           fieldSpec,
	output mixPkg::mixWord      newWord
);
	import mixPkg::*;

	logic withSign;

	assign withSign = fieldSpec[5:3] == 3'd0;

	always_comb begin : merge
		int firstByte;
		int lastByte;
		lastByte = int'(fieldSpec[2:0]);
		firstByte = withSign ? 1 : int'(fieldSpec[5:3]);
		newWord = oldWord;
		if (withSign) begin
			newWord[wordWidth-1] = source[wordWidth-1];
		end
		// byte n of memory takes source byte R-n counted from the right
		if (lastByte <= wordBytes) begin
			for (int n = 1; n <= wordBytes; n++) begin
				if (n >= firstByte && n <= lastByte) begin
					newWord[byteWidth*(wordBytes-n) +: byteWidth] =
						source[byteWidth*(lastByte-n) +: byteWidth];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/mixCompare.sv
/*
 Sign-magnitude comparator with a one-cycle start/stop handshake.
 +0 and -0 compare equal.
*/
`timescale 1ns/100ps
`default_nettype none

module mixCompare (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 start,
	input  wire mixPkg::mixWord in1,
	input  wire mixPkg::mixWord in2,
	output logic                stop,
	output logic [1:0]          code
);
	import mixPkg::*;

	logic sign1;
	logic sign2;
	logic [wordWidth-2:0] mag1;
	logic [wordWidth-2:0] mag2;

	always_ff @(posedge clk) begin
		if (reset) begin
			stop <= 1'b0;
		end else begin
			stop <= start;
		end
	end

	assign sign1 = in1[wordWidth-1];
	assign sign2 = in2[wordWidth-1];
	assign mag1 = in1[wordWidth-2:0];
	assign mag2 = in2[wordWidth-2:0];

	always_comb begin
		if (mag1 == '0 && mag2 == '0) begin
			code = cmpEqual;
		end else if (sign1 != sign2) begin
			code = sign1 ? cmpLess : cmpGreater;
		end else if (mag1 == mag2) begin
			code = cmpEqual;
		end else if ((mag1 > mag2) ^ sign1) begin
			// larger magnitude wins for positives, loses for negatives
			code = cmpGreater;
		end else begin
			code = cmpLess;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mixAddSub.sv
/*
 Sign-magnitude adder/subtractor. The result and overflow follow the
 operands combinationally, stop is the start strobe one cycle later.
*/
`timescale 1ns/100ps
`default_nettype none

module mixAddSub (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 start,
	input  wire                 subtract,
	input  wire mixPkg::mixWord in1,
	input  wire mixPkg::mixWord in2,
	output logic                stop,
	output mixPkg::mixWord      sum,
	output logic                overflow
);
	import mixPkg::*;

	localparam int magWidth = wordWidth - 1;

	logic sign1;
	logic sign2;
	logic [magWidth-1:0] mag1;
	logic [magWidth-1:0] mag2;
	logic [magWidth:0] total;
	logic resultSign;

	always_ff @(posedge clk) begin
		if (reset) begin
			stop <= 1'b0;
		end else begin
			stop <= start;
		end
	end

	// subtraction is addition with the second sign flipped
	assign sign1 = in1[magWidth];
	assign sign2 = in2[magWidth] ^ subtract;
	assign mag1 = in1[magWidth-1:0];
	assign mag2 = in2[magWidth-1:0];

	always_comb begin
		if (sign1 == sign2) begin
			total = {1'b0, mag1} + {1'b0, mag2};
			resultSign = sign1;
		end else if (mag1 >= mag2) begin
			// equal magnitudes give zero with the sign of in1
			total = {1'b0, mag1 - mag2};
			resultSign = sign1;
		end else begin
			total = {1'b0, mag2 - mag1};
			resultSign = sign2;
		end
	end

	assign sum = {resultSign, total[magWidth-1:0]};
	// carry out of the 30-bit magnitude
	assign overflow = total[magWidth];

endmodule

`default_nettype wire

// File: hdl/mixField.sv
/*
 Field extraction: takes bytes max(L,1)..R of a word, right-aligns
 them and keeps the sign only when L is zero.
*/
`timescale 1ns/100ps
`default_nettype none

module mixField (
	input  wire mixPkg::mixWord word,
	input  wire [5:0]           fieldSpec,
	output mixPkg::mixWord      value
);
	import mixPkg::*;

	logic [wordWidth-2:0] mag;
	logic withSign;

	assign withSign = fieldSpec[5:3] == 3'd0;

	always_comb begin : extract
		int firstByte;
		int lastByte;
		int count;
		lastByte = int'(fieldSpec[2:0]);
		firstByte = withSign ? 1 : int'(fieldSpec[5:3]);
		// L > R or R past byte 5 leaves an empty field
		if (lastByte > wordBytes || lastByte < firstByte) begin
			count = 0;
		end else begin
			count = lastByte - firstByte + 1;
		end
		mag = '0;
		// byte k from the right comes from byte number R-k
		for (int k = 0; k < wordBytes; k++) begin
			if (k < count) begin
				mag[byteWidth*k +: byteWidth] =
					word[byteWidth*(wordBytes-lastByte+k) +: byteWidth];
			end
		end
	end

	assign value = {withSign ? word[wordWidth-1] : 1'b0, mag};

endmodule

`default_nettype wire

// File: hdl/mixIndex.sv
/*
 Effective address: adds the selected index register to the signed
 instruction address, both in sign-magnitude form.
*/
`timescale 1ns/100ps
`default_nettype none

module mixIndex (
	input  wire mixPkg::mixIndexReg addressIn,
	input  wire [2:0]               indexSel,
	input  wire mixPkg::mixIndexReg i1,
	input  wire mixPkg::mixIndexReg i2,
	input  wire mixPkg::mixIndexReg i3,
	input  wire mixPkg::mixIndexReg i4,
	input  wire mixPkg::mixIndexReg i5,
	input  wire mixPkg::mixIndexReg i6,
	output mixPkg::mixIndexReg      effAddress
);
	import mixPkg::*;

	mixIndexReg offset;
	logic [addrWidth-1:0] addrMag;
	logic [addrWidth-1:0] offMag;

	// index 0 adds +0 and keeps the address as it is
	always_comb begin
		case (indexSel)
			3'd1: offset = i1;
			3'd2: offset = i2;
			3'd3: offset = i3;
			3'd4: offset = i4;
			3'd5: offset = i5;
			3'd6: offset = i6;
			default: offset = '0;
		endcase
	end

	assign addrMag = addressIn[addrWidth-1:0];
	assign offMag = offset[addrWidth-1:0];

	// magnitude wraps at 12 bits
	always_comb begin
		if (addressIn[addrWidth] == offset[addrWidth]) begin
			effAddress = {addressIn[addrWidth], addrMag + offMag};
		end else if (addrMag >= offMag) begin
			effAddress = {addressIn[addrWidth], addrMag - offMag};
		end else begin
			effAddress = {offset[addrWidth], offMag - addrMag};
		end
	end

endmodule

`default_nettype wire

// File: hdl/mixPkg.sv
/*
 MIX package: word geometry, instruction layout, opcode numbers,
 field-spec values, jump conditions and the comparison indicator.
*/
`default_nettype none

package mixPkg;

	localparam int wordWidth = 31;
	localparam int byteWidth = 6;
	localparam int wordBytes = 5;
	localparam int addrWidth = 12;

	typedef logic [wordWidth-1:0] mixWord;
	typedef logic [addrWidth-1:0] mixAddr;
	// sign plus 12-bit magnitude
	typedef logic [addrWidth:0] mixIndexReg;

	// instruction layout is +AA I F C
	localparam int addrFieldHi = 30;
	localparam int addrFieldLo = 18;
	localparam int indexFieldHi = 17;
	localparam int indexFieldLo = 12;
	localparam int specFieldHi = 11;
	localparam int specFieldLo = 6;
	localparam int opFieldHi = 5;
	localparam int opFieldLo = 0;

	localparam logic [5:0] opNop = 6'd0;
	localparam logic [5:0] opAdd = 6'd1;
	localparam logic [5:0] opSub = 6'd2;
	localparam logic [5:0] opSpecial = 6'd5;
	localparam logic [5:0] opLdBase = 6'd8;
	localparam logic [5:0] opLdnBase = 6'd16;
	localparam logic [5:0] opStBase = 6'd24;
	localparam logic [5:0] opStj = 6'd32;
	localparam logic [5:0] opStz = 6'd33;
	localparam logic [5:0] opJmp = 6'd39;
	localparam logic [5:0] opIdeBase = 6'd48;
	localparam logic [5:0] opCmpBase = 6'd56;

	// field values with a fixed meaning
	localparam logic [5:0] fieldHlt = 6'd2;
	localparam logic [5:0] fieldInc = 6'd0;
	localparam logic [5:0] fieldDec = 6'd1;
	localparam logic [5:0] fieldEnt = 6'd2;
	localparam logic [5:0] fieldEnn = 6'd3;

	// JMP conditions in the field
	localparam logic [5:0] jmpAlways = 6'd0;
	localparam logic [5:0] jmpSaveJ = 6'd1;
	localparam logic [5:0] jmpOverflow = 6'd2;
	localparam logic [5:0] jmpNoOverflow = 6'd3;
	localparam logic [5:0] jmpLess = 6'd4;
	localparam logic [5:0] jmpEqual = 6'd5;
	localparam logic [5:0] jmpGreater = 6'd6;
	localparam logic [5:0] jmpGreaterEqual = 6'd7;
	localparam logic [5:0] jmpNotEqual = 6'd8;
	localparam logic [5:0] jmpLessEqual = 6'd9;

	localparam logic [1:0] cmpEqual = 2'd0;
	localparam logic [1:0] cmpLess = 2'd1;
	localparam logic [1:0] cmpGreater = 2'd2;

endpackage

`default_nettype wire
